// File: vlog.f
+incdir+bench
src/usb_tx_pkg.sv
src/usb_pkt_reg.sv
src/usb_bit_serializer.sv
src/usb_crc_gen.sv
src/usb_bit_stuffer.sv
src/usb_nrzi_driver.sv
src/usb_tx_top.sv
bench/usb_tx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := usb_tx_tb
FLIST     := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/usb_tx_tb_tasks.svh
// **************************************************
// compare tasks
// **************************************************
task automatic check_bits(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_pid(input string name, input usb_tx_pkg::usb_pid_e got,
                         input usb_tx_pkg::usb_pid_e exp);
    if (got !== exp) begin
        $display("FAIL t=%0t %s got %b exp %b (%s)", $time, name, got, exp, exp.name());
        err_cnt++;
    end
endtask

task automatic check_line(input string name, input usb_tx_pkg::line_state_e got,
                          input usb_tx_pkg::line_state_e exp);
    if (got !== exp) begin
        $display("FAIL t=%0t %s got %s exp %s", $time, name, got.name(), exp.name());
        err_cnt++;
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("FAIL t=%0t %s got %0d exp %0d", $time, name, got, exp);
        err_cnt++;
    end
endtask

task automatic end_test(input string name, input int errs0);
    test_cnt++;
    if (err_cnt != errs0) bad_tests++;
    $display("test %s: %s", name, (err_cnt == errs0) ? "ok" : "failed");
endtask

// **************************************************
// reference models
// **************************************************
// serial crc over the field bits, preset all ones, raw register returned
function automatic logic [15:0] crc_run(input logic bits[$], input int clen,
                                        input logic [15:0] poly);
    logic [15:0] r;
    logic [15:0] top;
    logic        fb;
    r   = '1;
    top = 16'(32'd1 << (clen - 1));
    for (int i = usb_tx_pkg::FIELD_START; i < bits.size(); i++) begin
        fb = bits[i] ^ (|(r & top));
        r  = {r[14:0], 1'b0} ^ (fb ? poly : 16'h0);
    end
    return r & 16'((32'd1 << clen) - 32'd1);
endfunction

// six ones in a row cost one zero
function automatic int stuff_model(input logic bits[$]);
    int ones;
    int n;
    ones = 0;
    n    = 0;
    foreach (bits[i]) begin
        ones = bits[i] ? ones + 1 : 0;
        if (ones == usb_tx_pkg::STUFF_RUN) begin
            n++;
            ones = 0;
        end
    end
    return n;
endfunction

task automatic push_bits(input logic [63:0] v, input int len, input logic msb_first);
    for (int i = 0; i < len; i++) begin
        exp_bits.push_back(1'(v >> (msb_first ? len - 1 - i : i)));
    end
endtask

task automatic build_expected(input usb_tx_pkg::usb_pid_e p,
                              input logic [usb_tx_pkg::ADDR_W-1:0] a,
                              input logic [usb_tx_pkg::ENDP_W-1:0] e,
                              input logic [usb_tx_pkg::DATA_W-1:0] d);
    exp_bits.delete();
    exp_crc = '0;
    push_bits(64'(usb_tx_pkg::SYNC_PATTERN), 8, 1'b0);
    push_bits(64'(p), usb_tx_pkg::PID_W, 1'b0);
    push_bits(64'(~p), usb_tx_pkg::PID_W, 1'b0);   // check field
    if (p == usb_tx_pkg::PID_OUT || p == usb_tx_pkg::PID_IN) begin
        push_bits(64'(a), usb_tx_pkg::ADDR_W, 1'b0);
        push_bits(64'(e), usb_tx_pkg::ENDP_W, 1'b0);
        exp_crc = ~crc_run(exp_bits, 5, 16'(usb_tx_pkg::CRC5_POLY)) & 16'h001f;
        push_bits(64'(exp_crc), 5, 1'b1);          // msb first on the wire
    end else if (p == usb_tx_pkg::PID_DATA0) begin
        push_bits(d, usb_tx_pkg::DATA_W, 1'b0);
        exp_crc = ~crc_run(exp_bits, 16, 16'h8005);
        push_bits(64'(exp_crc), 16, 1'b1);
    end
endtask

// **************************************************
// receive side
// **************************************************
task automatic decode_line();
    usb_tx_pkg::line_state_e prev;
    logic                    b;
    int                      ones;
    int                      n;
    rx_bits.delete();
    rx_stuffs = 0;
    prev      = usb_tx_pkg::LINE_J;   // idle J before sync
    ones      = 0;
    n         = rx_line.size() - 3;   // eop is the last three
    if (n < 0) begin
        $display("line record too short for an eop at t=%0t", $time);
        err_cnt++;
        return;
    end
    for (int i = 0; i < n; i++) begin
        b    = (rx_line[i] == prev);  // no change means one
        prev = rx_line[i];
        if (ones == usb_tx_pkg::STUFF_RUN) begin
            if (b) begin
                $display("no stuff zero after six ones at line bit %0d", i);
                err_cnt++;
            end
            rx_stuffs++;
            ones = 0;
        end else begin
            rx_bits.push_back(b);
            ones = b ? ones + 1 : 0;
        end
    end
    check_line("eop 0", rx_line[n], usb_tx_pkg::LINE_SE0);
    check_line("eop 1", rx_line[n + 1], usb_tx_pkg::LINE_SE0);
    check_line("eop 2", rx_line[n + 2], usb_tx_pkg::LINE_J);
endtask

function automatic logic [63:0] field_at(input int pos, input int len, input logic msb_first);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < len; i++) begin
        if (pos + i < rx_bits.size()) begin
            if (msb_first) v = {v[62:0], rx_bits[pos + i]};
            else v = v | (64'(rx_bits[pos + i]) << i);
        end
    end
    return v;
endfunction

// **************************************************
// directed tests
// **************************************************
task automatic run_packet(input string name, input usb_tx_pkg::usb_pid_e p,
                          input logic [usb_tx_pkg::ADDR_W-1:0] a,
                          input logic [usb_tx_pkg::ENDP_W-1:0] e,
                          input logic [usb_tx_pkg::DATA_W-1:0] d,
                          input logic intrude);
    int errs0;
    int stuffs;
    int cycles;   // accepting edge to done edge
    errs0 = err_cnt;
    build_expected(p, a, e, d);
    stuffs = stuff_model(exp_bits);
    send_packet(p, a, e, d, intrude, cycles);
    decode_line();
    check_bits("sync", field_at(0, 8, 1'b0), 64'(usb_tx_pkg::SYNC_PATTERN));
    check_pid("pid", usb_tx_pkg::usb_pid_e'(4'(field_at(8, 4, 1'b0))), p);
    check_bits("npid", field_at(12, 4, 1'b0), {60'd0, ~p});
    case (p)
        usb_tx_pkg::PID_OUT, usb_tx_pkg::PID_IN: begin
            check_bits("addr", field_at(16, 7, 1'b0), 64'(a));
            check_bits("endp", field_at(23, 4, 1'b0), 64'(e));
            check_bits("crc5", field_at(27, 5, 1'b1), 64'(exp_crc));
            check_bits("crc5 residue",
                       64'(crc_run(rx_bits, 5, 16'(usb_tx_pkg::CRC5_POLY))), 64'h0c);
        end
        usb_tx_pkg::PID_DATA0: begin
            check_bits("data", field_at(16, 64, 1'b0), d);
            check_bits("crc16", field_at(80, 16, 1'b1), 64'(exp_crc));
            check_bits("crc16 residue", 64'(crc_run(rx_bits, 16, 16'h8005)), 64'h800d);
        end
        default: check_count("crc bits", rx_bits.size() - usb_tx_pkg::FIELD_START, 0);
    endcase
    check_count("frame bits", rx_bits.size(), exp_bits.size());
    check_count("stuff bits", rx_stuffs, stuffs);
    check_count("cycles", cycles, exp_bits.size() + stuffs + 3);
    end_test(name, errs0);
endtask

task automatic refuse_undefined();
    int errs0;
    int n;
    errs0 = err_cnt;
    @(negedge clk);
    start = 1'b1;
    pid   = usb_tx_pkg::usb_pid_e'(4'b0111);   // not one of the five
    n     = 0;
    while (!busy && n < 20) begin
        @(negedge clk);
        n++;
    end
    start = 1'b0;
    if (busy) begin
        $display("busy rose for an undefined pid at t=%0t", $time);
        err_cnt++;
    end
    check_bits("line_active", 64'(line_active), 64'd0);
    end_test("undefined pid", errs0);
endtask

task automatic reset_mid_packet();
    int errs0;
    errs0 = err_cnt;
    @(negedge clk);
    start = 1'b1;
    pid   = usb_tx_pkg::PID_DATA0;
    data  = {$random(seed), $random(seed)};
    @(negedge clk);
    start = 1'b0;
    repeat (30) @(negedge clk);   // well inside the payload
    check_bits("busy", 64'(busy), 64'd1);   // packet still in flight
    check_bits("line_active", 64'(line_active), 64'd1);
    rst_L = 1'b0;
    @(negedge clk);
    check_bits("busy", 64'(busy), 64'd0);
    check_bits("done", 64'(done), 64'd0);
    check_bits("line_active", 64'(line_active), 64'd0);
    check_line("line", line, usb_tx_pkg::LINE_J);
    repeat (2) @(negedge clk);
    rst_L = 1'b1;
    end_test("reset during data0", errs0);
    run_packet("ack after reset", usb_tx_pkg::PID_ACK, '0, '0, '0, 1'b0);
endtask

// File: bench/usb_tx_tb.sv
module usb_tx_tb;

    logic                                 clk;
    logic                                 rst_L;
    logic                                 start;
    usb_tx_pkg::usb_pid_e                 pid;
    logic [usb_tx_pkg::ADDR_W-1:0]        addr;
    logic [usb_tx_pkg::ENDP_W-1:0]        endp;
    logic [usb_tx_pkg::DATA_W-1:0]        data;
    logic                                 busy;
    logic                                 done;
    logic                                 line_active;
    usb_tx_pkg::line_state_e              line;

    usb_tx_pkg::line_state_e rx_line[$];   // line states while active, eop included
    logic                    rx_bits[$];   // nrzi decoded, stuff zeros removed
    logic                    exp_bits[$];  // body + crc from the model
    logic [15:0]             exp_crc;
    int                      rx_stuffs;
    int                      err_cnt;
    int                      test_cnt;
    int                      bad_tests;
    integer                  seed;

    usb_tx_top i_dut (
        .clk(clk), .rst_L(rst_L), .start(start), .pid(pid), .addr(addr), .endp(endp),
        .data(data), .busy(busy), .done(done), .line_active(line_active), .line(line)
    );

    `include "usb_tx_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // **************************************************
    // line monitor, samples mid cycle
    // **************************************************
    always @(negedge clk) begin
        if (rst_L && line_active) rx_line.push_back(line);
    end

    // drive one request, then wait for done and check its shape
    task automatic send_packet(input usb_tx_pkg::usb_pid_e p,
                               input logic [usb_tx_pkg::ADDR_W-1:0] a,
                               input logic [usb_tx_pkg::ENDP_W-1:0] e,
                               input logic [usb_tx_pkg::DATA_W-1:0] d,
                               input logic intrude,
                               output int cycles);
        int n;   // negedges since the accepting edge
        @(negedge clk);
        rx_line.delete();
        start = 1'b1;
        pid   = p;
        addr  = a;
        endp  = e;
        data  = d;
        @(negedge clk);
        start = 1'b0;
        n     = 0;
        check_bits("busy", 64'(busy), 64'd1);   // accepted at the edge just gone
        if (intrude) begin                       // second request while busy
            start = 1'b1;
            pid   = usb_tx_pkg::PID_NAK;
            addr  = ~a;
            data  = ~d;
            @(negedge clk);
            n++;
            start = 1'b0;
        end
        while (!done && n < 300) begin
            @(negedge clk);
            n++;
        end
        cycles = n + 1;   // done edge closes the current cycle
        if (!done) begin
            $display("timeout at t=%0t: done never pulsed", $time);
            err_cnt++;
        end else begin
            check_bits("line_active", 64'(line_active), 64'd1);   // still in the J cycle
            check_bits("busy", 64'(busy), 64'd1);
            @(negedge clk);
            check_bits("done", 64'(done), 64'd0);                 // one cycle only
            check_bits("line_active", 64'(line_active), 64'd0);
            check_bits("busy", 64'(busy), 64'd0);
        end
    endtask

    initial begin
        seed      = 93412;
        err_cnt   = 0;
        test_cnt  = 0;
        bad_tests = 0;
        rst_L     = 1'b0;
        start     = 1'b0;
        pid       = usb_tx_pkg::PID_ACK;
        addr      = '0;
        endp      = '0;
        data      = '0;
        repeat (3) @(negedge clk);
        rst_L = 1'b1;

        run_packet("out token", usb_tx_pkg::PID_OUT, 7'h3a, 4'h5, '0, 1'b0);
        run_packet("in token all ones", usb_tx_pkg::PID_IN, 7'h7f, 4'hf, '0, 1'b0);
        run_packet("data0 random", usb_tx_pkg::PID_DATA0, '0, '0,
                   {$random(seed), $random(seed)}, 1'b0);
        run_packet("data0 all ones", usb_tx_pkg::PID_DATA0, '0, '0, '1, 1'b0);
        run_packet("ack", usb_tx_pkg::PID_ACK, '0, '0, '0, 1'b0);
        run_packet("nak", usb_tx_pkg::PID_NAK, '0, '0, '0, 1'b0);
        run_packet("start while busy", usb_tx_pkg::PID_DATA0, '0, '0,
                   {$random(seed), $random(seed)}, 1'b1);
        refuse_undefined();
        reset_mid_packet();

        $display("%0d tests, %0d failed, %0d errors", test_cnt, bad_tests, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src/usb_tx_top.sv
module usb_tx_top (
    input  logic                            clk,
    input  logic                            rst_L,
    input  logic                            start,
    input  usb_tx_pkg::usb_pid_e            pid,
    input  logic [usb_tx_pkg::ADDR_W-1:0]   addr,
    input  logic [usb_tx_pkg::ENDP_W-1:0]   endp,
    input  logic [usb_tx_pkg::DATA_W-1:0]   data,
    output logic                            busy,
    output logic                            done,
    output logic                            line_active,
    output usb_tx_pkg::line_state_e         line
);
    logic                                 launch;
    logic [usb_tx_pkg::FRAME_MAX-1:0]     frame;
    logic [usb_tx_pkg::FRAME_CNT_W-1:0]   body_len;
    usb_tx_pkg::crc_kind_e                crc_kind;
    logic                                 ser_bit;
    logic                                 field_bit;
    logic                                 body_last;
    logic                                 crc_bit;
    logic                                 frame_last;
    logic                                 stuff_bit;
    logic                                 frame_end;
    logic                                 stall;   // from the stuffer back up the stream

    usb_pkt_reg i_pkt_reg (
        .clk(clk), .rst_L(rst_L), .start(start), .pid(pid), .addr(addr), .endp(endp),
        .data(data), .done(done), .busy(busy), .launch(launch), .frame(frame),
        .body_len(body_len), .crc_kind(crc_kind)
    );

    usb_bit_serializer i_serializer (
        .clk(clk), .rst_L(rst_L), .launch(launch), .stall(stall), .frame(frame),
        .body_len(body_len), .ser_bit(ser_bit), .field_bit(field_bit), .body_last(body_last)
    );

    usb_crc_gen i_crc_gen (
        .clk(clk), .rst_L(rst_L), .crc_kind(crc_kind), .ser_bit(ser_bit),
        .field_bit(field_bit), .body_last(body_last), .stall(stall), .crc_bit(crc_bit),
        .frame_last(frame_last)
    );

    usb_bit_stuffer i_stuffer (
        .clk(clk), .rst_L(rst_L), .launch(launch), .crc_bit(crc_bit),
        .frame_last(frame_last), .stuff_bit(stuff_bit), .stall(stall), .frame_end(frame_end)
    );

    usb_nrzi_driver i_nrzi (
        .clk(clk), .rst_L(rst_L), .launch(launch), .stuff_bit(stuff_bit),
        .frame_end(frame_end), .line_active(line_active), .line(line), .done(done)
    );

endmodule

// File: src/usb_nrzi_driver.sv
module usb_nrzi_driver (
    input  logic                    clk,
    input  logic                    rst_L,
    input  logic                    launch,
    input  logic                    stuff_bit,
    input  logic                    frame_end,
    output logic                    line_active,
    output usb_tx_pkg::line_state_e line,
    output logic                    done
);
    typedef enum logic [1:0] {IDLE, SEND, EOP} nrzi_state_e;

    nrzi_state_e             state;
    logic [1:0]              eop_cnt;   // 0,1 se0 then J
    usb_tx_pkg::line_state_e prev;      // line state of the previous bit
    logic                    sending;

    assign sending     = launch || (state == SEND);
    assign line_active = sending || (state == EOP);
    assign done        = (state == EOP) && (eop_cnt == 2'(usb_tx_pkg::EOP_SE0_CYCLES));

    // **************************************************
    // line encoding
    // **************************************************
    always_comb begin
        if (sending)
            line = stuff_bit ? prev : usb_tx_pkg::line_state_e'(~prev);   // zero toggles J/K
        else if (state == EOP && !done)
            line = usb_tx_pkg::LINE_SE0;
        else
            line = usb_tx_pkg::LINE_J;   // idle and final eop cycle
    end

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            state   <= IDLE;
            eop_cnt <= '0;
            prev    <= usb_tx_pkg::LINE_J;   // encoder starts from J
        end else if (sending) begin
            prev <= line;
            if (frame_end) begin
                state   <= EOP;
                eop_cnt <= '0;
            end else begin
                state <= SEND;
            end
        end else if (state == EOP) begin
            if (done) begin
                state <= IDLE;
                prev  <= usb_tx_pkg::LINE_J;
            end else begin
                eop_cnt <= eop_cnt + 1'b1;
            end
        end
    end

    // idle line stays J
    a_se0_active: assert property (@(posedge clk) disable iff (!rst_L)
        (line == usb_tx_pkg::LINE_SE0) |-> line_active);

endmodule

// File: src/usb_bit_stuffer.sv
module usb_bit_stuffer (
    input  logic clk,
    input  logic rst_L,
    input  logic launch,
    input  logic crc_bit,
    input  logic frame_last,
    output logic stuff_bit,
    output logic stall,
    output logic frame_end
);
    logic [2:0] ones_cnt;    // run of ones already sent
    logic       active;      // inside a frame after the launch cycle
    logic       last_pend;   // last bit was a sixth one, end moves to the stuff cycle
    logic       valid;
    logic       stuffing;
    logic       sixth;

    assign valid     = launch || active;
    assign stuffing  = (ones_cnt == 3'(usb_tx_pkg::STUFF_RUN));
    assign sixth     = crc_bit && (ones_cnt == 3'(usb_tx_pkg::STUFF_RUN - 1));
    assign stall     = stuffing;                     // upstream holds for one cycle
    assign stuff_bit = stuffing ? 1'b0 : crc_bit;    // inserted zero
    assign frame_end = valid && (stuffing ? last_pend : (frame_last && !sixth));

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            active    <= 1'b0;
            ones_cnt  <= '0;
            last_pend <= 1'b0;
        end else if (frame_end) begin   // clean slate for the next frame
            active    <= 1'b0;
            ones_cnt  <= '0;
            last_pend <= 1'b0;
        end else if (valid) begin
            active <= 1'b1;
            if (stuffing) begin
                ones_cnt <= '0;
            end else if (crc_bit) begin
                ones_cnt  <= ones_cnt + 1'b1;
                last_pend <= frame_last && sixth;
            end else begin
                ones_cnt <= '0;   // any zero breaks the run
            end
        end
    end

    // count restarts after a stuff, so stalls never come back to back
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_L)
        stall |=> !stall);

endmodule

// File: src/usb_crc_gen.sv
module usb_crc_gen (
    input  logic                  clk,
    input  logic                  rst_L,
    input  usb_tx_pkg::crc_kind_e crc_kind,
    input  logic                  ser_bit,
    input  logic                  field_bit,
    input  logic                  body_last,
    input  logic                  stall,
    output logic                  crc_bit,
    output logic                  frame_last
);
    // IDLE covers sync/pid/npid, PASS the crc-covered fields
    typedef enum logic [1:0] {PASS, SHIFT_OUT, IDLE} crc_state_e;

    crc_state_e                          state;
    logic [usb_tx_pkg::CRC16_LEN-1:0]    crc;       // crc5 lives in the low bits
    logic [usb_tx_pkg::CRC16_LEN-1:0]    crc_nxt;
    logic [usb_tx_pkg::CRC16_LEN-1:0]    poly;
    logic [3:0]                          top_idx;   // msb of the active remainder
    logic [3:0]                          cnt;       // remainder bit being sent
    logic                                fb;

    always_comb begin
        poly = '0;
        if (crc_kind == usb_tx_pkg::CRC_5) begin
            poly[usb_tx_pkg::CRC5_LEN-1:0] = usb_tx_pkg::CRC5_POLY;
            top_idx = 4'(usb_tx_pkg::CRC5_LEN - 1);
        end else begin
            poly    = usb_tx_pkg::CRC16_POLY;
            top_idx = 4'(usb_tx_pkg::CRC16_LEN - 1);
        end
    end

    // **************************************************
    // lfsr step, shift left and fold in the poly
    // **************************************************
    assign fb      = crc[top_idx] ^ ser_bit;
    assign crc_nxt = {crc[usb_tx_pkg::CRC16_LEN-2:0], 1'b0} ^ (fb ? poly : '0);

    assign crc_bit    = (state == SHIFT_OUT) ? ~crc[cnt] : ser_bit;   // complemented remainder
    assign frame_last = (state == SHIFT_OUT) ? (cnt == '0)
                                             : (body_last && crc_kind == usb_tx_pkg::CRC_NONE);

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            state <= IDLE;
            crc   <= '1;
            cnt   <= '0;
        end else if (!stall) begin
            case (state)
                IDLE, PASS: begin
                    if (field_bit) begin
                        crc   <= crc_nxt;   // first field bit sees the all-ones preset
                        state <= PASS;
                        if (body_last) begin
                            state <= SHIFT_OUT;
                            cnt   <= top_idx;   // msb first
                        end
                    end else begin
                        crc   <= '1;
                        state <= IDLE;
                    end
                end
                SHIFT_OUT: begin
                    if (cnt == '0) state <= IDLE;
                    else cnt <= cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // handshakes carry no crc, so no remainder may go out
    a_no_crc_none: assert property (@(posedge clk) disable iff (!rst_L)
        (state == SHIFT_OUT) |-> (crc_kind != usb_tx_pkg::CRC_NONE));

endmodule

// File: src/usb_bit_serializer.sv
module usb_bit_serializer (
    input  logic                                    clk,
    input  logic                                    rst_L,
    input  logic                                    launch,
    input  logic                                    stall,
    input  logic [usb_tx_pkg::FRAME_MAX-1:0]        frame,
    input  logic [usb_tx_pkg::FRAME_CNT_W-1:0]      body_len,
    output logic                                    ser_bit,
    output logic                                    field_bit,
    output logic                                    body_last
);
    typedef enum logic {IDLE, SEND} ser_state_e;

    ser_state_e                           state;
    logic [usb_tx_pkg::FRAME_CNT_W-1:0]   idx;      // current frame bit
    logic                                 active;

    // bit 0 already goes out in the launch cycle
    assign active    = launch || (state == SEND);
    assign ser_bit   = active && frame[idx];
    assign field_bit = active &&
                       (idx >= usb_tx_pkg::FRAME_CNT_W'(usb_tx_pkg::FIELD_START));
    assign body_last = active && (idx == body_len - 1'b1);

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            state <= IDLE;
            idx   <= '0;
        end else if (active && !stall) begin   // stuff cycle holds the bit
            if (body_last) begin
                state <= IDLE;
                idx   <= '0;
            end else begin
                state <= SEND;
                idx   <= idx + 1'b1;
            end
        end
    end

endmodule

// File: src/usb_pkt_reg.sv
module usb_pkt_reg (
    input  logic                                    clk,
    input  logic                                    rst_L,
    input  logic                                    start,
    input  usb_tx_pkg::usb_pid_e                    pid,
    input  logic [usb_tx_pkg::ADDR_W-1:0]           addr,
    input  logic [usb_tx_pkg::ENDP_W-1:0]           endp,
    input  logic [usb_tx_pkg::DATA_W-1:0]           data,
    input  logic                                    done,
    output logic                                    busy,
    output logic                                    launch,
    output logic [usb_tx_pkg::FRAME_MAX-1:0]        frame,
    output logic [usb_tx_pkg::FRAME_CNT_W-1:0]      body_len,
    output usb_tx_pkg::crc_kind_e                   crc_kind
);
    logic                                 pid_ok;     // pid is one of the five we send
    logic                                 accept;
    logic [usb_tx_pkg::PID_W-1:0]         npid;
    logic [usb_tx_pkg::FRAME_MAX-1:0]     nxt_frame;
    logic [usb_tx_pkg::FRAME_CNT_W-1:0]   nxt_len;
    usb_tx_pkg::crc_kind_e                nxt_kind;

    assign npid   = ~pid;   // check field
    assign accept = start && !busy && pid_ok;

    // frame layout by pid, bit 0 leaves first
    always_comb begin
        pid_ok    = 1'b1;
        nxt_frame = '0;
        nxt_len   = '0;
        nxt_kind  = usb_tx_pkg::CRC_NONE;
        case (pid)
            usb_tx_pkg::PID_OUT, usb_tx_pkg::PID_IN: begin   // token
                nxt_frame[usb_tx_pkg::FIELD_START+usb_tx_pkg::ADDR_W+usb_tx_pkg::ENDP_W-1:0] =
                    {endp, addr, npid, pid, usb_tx_pkg::SYNC_PATTERN};
                nxt_len  = usb_tx_pkg::FRAME_CNT_W'(usb_tx_pkg::FIELD_START +
                                                    usb_tx_pkg::ADDR_W + usb_tx_pkg::ENDP_W);
                nxt_kind = usb_tx_pkg::CRC_5;
            end
            usb_tx_pkg::PID_DATA0: begin
                nxt_frame = {data, npid, pid, usb_tx_pkg::SYNC_PATTERN};
                nxt_len   = usb_tx_pkg::FRAME_CNT_W'(usb_tx_pkg::FRAME_MAX);
                nxt_kind  = usb_tx_pkg::CRC_16;
            end
            usb_tx_pkg::PID_ACK, usb_tx_pkg::PID_NAK: begin   // handshake, no fields
                nxt_frame[usb_tx_pkg::FIELD_START-1:0] = {npid, pid, usb_tx_pkg::SYNC_PATTERN};
                nxt_len = usb_tx_pkg::FRAME_CNT_W'(usb_tx_pkg::FIELD_START);
            end
            default: pid_ok = 1'b0;   // undefined pid is refused
        endcase
    end

    always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L) begin
            busy     <= 1'b0;
            launch   <= 1'b0;
            body_len <= '0;
            crc_kind <= usb_tx_pkg::CRC_NONE;
        end else begin
            launch <= accept;   // one cycle after acceptance
            if (accept) begin
                busy     <= 1'b1;
                body_len <= nxt_len;
                crc_kind <= nxt_kind;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) frame <= nxt_frame;   // held until the next accepted request
    end

    // a second request while one is in flight must not disturb it
    a_frame_held: assert property (@(posedge clk) disable iff (!rst_L)
        (start && busy && pid_ok) |=> $stable(frame));

endmodule

// File: src/usb_tx_pkg.sv
package usb_tx_pkg;

    // **************************************************
    // field widths
    // **************************************************
    localparam int PID_W  = 4;
    localparam int ADDR_W = 7;
    localparam int ENDP_W = 4;
    localparam int DATA_W = 64;

    // sync goes out lsb first, so the lone one is the last sync bit
    localparam logic [7:0] SYNC_PATTERN = 8'b1000_0000;

    localparam int FRAME_MAX   = 80;   // sync + pid + npid + data
    localparam int FRAME_CNT_W = 7;    // enough to index FRAME_MAX bits
    localparam int FIELD_START = 16;   // first crc-covered bit

    // **************************************************
    // crc and line coding constants
    // **************************************************
    localparam logic [4:0]  CRC5_POLY  = 5'b0_0101;   // x^5 + x^2 + 1
    localparam logic [15:0] CRC16_POLY = 16'h8005;    // x^16 + x^15 + x^2 + 1
    localparam int CRC5_LEN  = 5;
    localparam int CRC16_LEN = 16;

    localparam int STUFF_RUN      = 6;   // ones before a forced zero
    localparam int EOP_SE0_CYCLES = 2;

    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_DATA0 = 4'b0011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010
    } usb_pid_e;

    typedef enum logic [1:0] {
        CRC_NONE,
        CRC_5,
        CRC_16
    } crc_kind_e;

    // d+ is the upper bit, d- the lower one
    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_K   = 2'b01,
        LINE_J   = 2'b10
    } line_state_e;

endpackage
